/* rtl/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter vectors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// first fetch address out of reset
`define CPU_RESET_VECTOR 32'h0000_0000

// handler address loaded when the machine is restarted out of TRAP
`define CPU_TRAP_VECTOR 32'h0000_0100

// one instruction word is four bytes
`define CPU_PC_STEP 4

`endif

/* rtl/cpu_pkg.sv */
package cpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequencing states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // bit 3 marks the running states, bit 4 the trap
  typedef enum logic [4:0] {
    HALT       = 5'b00000,
    READ_INS   = 5'b01000,
    DO         = 5'b01001,
    WAIT_LOAD  = 5'b01010,
    WAIT_STORE = 5'b01100,
    TRAP       = 5'b10000
  } ctrl_state_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decoded instruction fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // fields of the ALU format
  typedef struct packed {
    logic [2:0]  alu_op;
    logic [1:0]  alu_vec_perci;
    logic        alu_form;
    logic [3:0]  alu_config;
    logic        const_c;
    logic [31:0] constant;
    logic [1:0]  alu_write;
    logic        invalid;
    logic [3:0]  logic_select;
    logic [3:0]  alu_a_select;
  } alu_fields_t;

  // remaining operand selects pass straight through to the top level
  typedef struct packed {
    logic [3:0] alu_b_select;
    logic [3:0] alu_c_select;
    logic [3:0] alu_d_select;
    logic [3:0] alu_y1_select;
    logic [3:0] alu_y2_select;
  } operand_selects_t;

  // fields of the memory format
  typedef struct packed {
    logic [3:0] reg_addr;
    logic [3:0] mem_loca_addr;
    logic       st;
    logic       ld;
    logic [3:0] sl_select;
    logic [2:0] sl_op;
    logic [1:0] write;
    logic       invalid;
  } mmu_fields_t;

endpackage

/* rtl/alu_instruction_decoder.sv */
module alu_instruction_decoder (
  input  logic [31:0]               instruction,
  output cpu_pkg::alu_fields_t      fields,
  output cpu_pkg::operand_selects_t selects
);

  logic [15:0] const_raw;
  logic        reserved_op;
  logic        high_bit_set;

  // the constant field overlaps the a..d selects
  assign const_raw    = instruction[27:12];
  assign reserved_op  = (instruction[4:2] == 3'b111);
  assign high_bit_set = instruction[31];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operation and control fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    fields.alu_op        = instruction[4:2];
    fields.alu_vec_perci = instruction[6:5];
    fields.alu_form      = instruction[7];
    fields.alu_config    = instruction[11:8];
    fields.logic_select  = instruction[11:8]; // same bits as the config field
    fields.alu_a_select  = instruction[15:12];
    fields.alu_write     = instruction[29:28];
    fields.const_c       = instruction[30];

    if (instruction[30]) begin
      fields.constant = {{16{const_raw[15]}}, const_raw};
    end else begin
      fields.constant = 32'd0;
    end

    // bit 31 is reserved for a future format
    fields.invalid = high_bit_set | reserved_op;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operand selects
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    selects.alu_b_select  = instruction[19:16];
    selects.alu_c_select  = instruction[23:20];
    selects.alu_d_select  = instruction[27:24];

    // the two result ports reuse the c and d fields
    selects.alu_y1_select = instruction[27:24];
    selects.alu_y2_select = instruction[23:20];
  end

endmodule

/* rtl/mmu_decoder.sv */
module mmu_decoder (
  input  logic [31:2]          instruction,
  output cpu_pkg::mmu_fields_t fields
);

  logic upper_set;
  logic both_access;

  // bits 31..21 are unused by the memory format and must stay clear
  assign upper_set   = |instruction[31:21];
  assign both_access = instruction[2] & instruction[3];

  always_comb begin
    fields.ld            = instruction[2];
    fields.st            = instruction[3];
    fields.reg_addr      = instruction[7:4];
    fields.mem_loca_addr = instruction[11:8];
    fields.sl_op         = instruction[14:12];
    fields.sl_select     = instruction[18:15];
    fields.write         = instruction[20:19];

    // a word may load or store but not both in one pass
    fields.invalid       = upper_set | both_access;
  end

endmodule

/* rtl/control_fsm.sv */
module control_fsm (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 go,
  input  logic                 halt,
  input  logic                 instr_alu,
  input  logic                 instr_pc,
  input  logic                 ld,
  input  logic                 st,
  input  logic                 wait_instr,
  input  logic                 wait_data,
  input  logic                 instr_segv,
  input  logic                 data_segv,
  input  logic                 invalid_instruction,
  output cpu_pkg::ctrl_state_t current_state
);

  cpu_pkg::ctrl_state_t next_state;
  logic                 mem_load;
  logic                 mem_store;

  // load and store bits only mean something in the memory format
  assign mem_load  = ~instr_alu & ld;
  assign mem_store = ~instr_alu & st;

  always_ff @(posedge clk) begin
    if (reset) begin
      current_state <= cpu_pkg::HALT;
    end else begin
      current_state <= next_state;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    next_state = current_state; // hold by default so the wait inputs freeze the state

    case (current_state)
      cpu_pkg::HALT: begin
        if (go) next_state = cpu_pkg::READ_INS;
      end
      cpu_pkg::READ_INS: begin
        if (instr_segv) next_state = cpu_pkg::TRAP;
        else if (wait_instr) next_state = cpu_pkg::READ_INS;
        else if (invalid_instruction) next_state = cpu_pkg::TRAP;
        else if (mem_load) next_state = cpu_pkg::WAIT_LOAD;
        else if (mem_store) next_state = cpu_pkg::WAIT_STORE;
        else next_state = cpu_pkg::DO; // ALU ops, jumps and register moves
      end
      cpu_pkg::WAIT_LOAD, cpu_pkg::WAIT_STORE: begin
        if (data_segv) next_state = cpu_pkg::TRAP;
        else if (!wait_data) next_state = cpu_pkg::DO;
      end
      cpu_pkg::DO: begin
        next_state = cpu_pkg::READ_INS;
      end
      cpu_pkg::TRAP: begin
        if (go) next_state = cpu_pkg::READ_INS;
      end
      default: begin
        next_state = cpu_pkg::HALT;
      end
    endcase

    // halt wins over every other condition
    if (halt) next_state = cpu_pkg::HALT;
  end

endmodule

/* rtl/controlpath.sv */
module controlpath (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      go,
  input  logic                      halt,
  input  logic [31:0]               instruction,
  input  logic                      instr_segv,
  input  logic                      data_segv,
  input  logic                      wait_instr,
  input  logic                      wait_data,
  output logic                      pc_inc,
  output logic                      pc_jump,
  output logic                      trap,
  output logic [2:0]                opcode,
  output logic                      alu_form,
  output logic [1:0]                alu_vec_perci,
  output logic [3:0]                alu_config,
  output logic                      const_c,
  output logic [31:0]               constant,
  output logic [3:0]                a_select,
  output cpu_pkg::operand_selects_t selects,
  output logic [1:0]                reg_write,
  output logic [3:0]                op_select,
  output logic                      st,
  output logic                      ld,
  output logic [3:0]                mem_loca_addr,
  output logic [3:0]                reg_addr
);

  cpu_pkg::alu_fields_t alu_f;
  cpu_pkg::mmu_fields_t mmu_f;
  cpu_pkg::ctrl_state_t current_state;
  logic                 instr_alu;
  logic                 instr_pc;
  logic                 invalid_instruction;
  logic [1:0]           reg_write_raw;
  logic                 in_do;

  assign instr_alu = instruction[0];
  assign instr_pc  = instruction[1];

  alu_instruction_decoder d0 (.instruction(instruction), .fields(alu_f), .selects(selects));

  mmu_decoder d1 (.instruction(instruction[31:2]), .fields(mmu_f));

  control_fsm controlfsm (
    .clk(clk), .reset(reset), .go(go), .halt(halt),
    .instr_alu(instr_alu), .instr_pc(instr_pc), .ld(mmu_f.ld), .st(mmu_f.st),
    .wait_instr(wait_instr), .wait_data(wait_data),
    .instr_segv(instr_segv), .data_segv(data_segv),
    .invalid_instruction(invalid_instruction), .current_state(current_state)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // format select between the two decoders
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    opcode              = instr_alu ? alu_f.alu_op       : mmu_f.sl_op;
    reg_write_raw       = instr_alu ? alu_f.alu_write    : mmu_f.write;
    op_select           = instr_alu ? alu_f.logic_select : mmu_f.sl_select;
    a_select            = instr_alu ? alu_f.alu_a_select : mmu_f.reg_addr;
    invalid_instruction = instr_alu ? alu_f.invalid      : mmu_f.invalid;
  end

  assign alu_form      = alu_f.alu_form;
  assign alu_vec_perci = alu_f.alu_vec_perci;
  assign alu_config    = alu_f.alu_config;
  assign const_c       = alu_f.const_c;
  assign constant      = alu_f.constant;
  assign mem_loca_addr = mmu_f.mem_loca_addr;
  assign reg_addr      = mmu_f.reg_addr;

  // strobes only fire in the state that owns them
  assign in_do     = (current_state == cpu_pkg::DO);
  assign reg_write = in_do ? reg_write_raw : 2'b00;
  assign pc_inc    = in_do;
  assign pc_jump   = in_do & instr_pc;
  assign ld        = (current_state == cpu_pkg::WAIT_LOAD);
  assign st        = (current_state == cpu_pkg::WAIT_STORE);
  assign trap      = (current_state == cpu_pkg::TRAP);

endmodule

/* rtl/program_counter.sv */
`include "cpu_params.svh"

module program_counter (
  input  logic        clk,
  input  logic        reset,
  input  logic        pc_inc,
  input  logic        pc_jump,
  input  logic        trap,
  input  logic        go,
  input  logic [31:0] constant,
  output logic [31:0] pc
);

  logic [31:0] pc_next;
  logic        restart;

  // go while trapped restarts fetch at the handler
  assign restart = trap & go;

  always_comb begin
    pc_next = pc;
    if (restart) begin
      pc_next = `CPU_TRAP_VECTOR;
    end else if (pc_inc) begin
      if (pc_jump) pc_next = constant; // absolute jump to the decoded constant
      else pc_next = pc + 32'(`CPU_PC_STEP);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `CPU_RESET_VECTOR;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

/* rtl/control_unit_top.sv */
module control_unit_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      go,
  input  logic                      halt,
  input  logic [31:0]               instruction,
  input  logic                      instr_segv,
  input  logic                      data_segv,
  input  logic                      wait_instr,
  input  logic                      wait_data,
  output logic                      pc_inc,
  output logic                      pc_jump,
  output logic                      trap,
  output logic [2:0]                opcode,
  output logic                      alu_form,
  output logic [1:0]                alu_vec_perci,
  output logic [3:0]                alu_config,
  output logic                      const_c,
  output logic [31:0]               constant,
  output logic [3:0]                a_select,
  output cpu_pkg::operand_selects_t selects,
  output logic [1:0]                reg_write,
  output logic [3:0]                op_select,
  output logic                      st,
  output logic                      ld,
  output logic [3:0]                mem_loca_addr,
  output logic [3:0]                reg_addr,
  output logic [31:0]               pc
);

  controlpath cp0 (
    .clk(clk), .reset(reset), .go(go), .halt(halt), .instruction(instruction),
    .instr_segv(instr_segv), .data_segv(data_segv),
    .wait_instr(wait_instr), .wait_data(wait_data),
    .pc_inc(pc_inc), .pc_jump(pc_jump), .trap(trap), .opcode(opcode),
    .alu_form(alu_form), .alu_vec_perci(alu_vec_perci), .alu_config(alu_config),
    .const_c(const_c), .constant(constant), .a_select(a_select), .selects(selects),
    .reg_write(reg_write), .op_select(op_select), .st(st), .ld(ld),
    .mem_loca_addr(mem_loca_addr), .reg_addr(reg_addr)
  );

  program_counter pc0 (
    .clk(clk), .reset(reset), .pc_inc(pc_inc), .pc_jump(pc_jump),
    .trap(trap), .go(go), .constant(constant), .pc(pc)
  );

endmodule

/* test/control_unit_assert.sv */
`include "cpu_params.svh"

module control_unit_assert (
  input logic                      clk,
  input logic                      reset,
  input logic                      go,
  input logic                      halt,
  input logic [31:0]               instruction,
  input logic                      wait_instr,
  input logic                      wait_data,
  input logic                      data_segv,
  input logic                      pc_inc,
  input logic                      pc_jump,
  input logic                      trap,
  input logic [2:0]                opcode,
  input logic                      alu_form,
  input logic [1:0]                alu_vec_perci,
  input logic [3:0]                alu_config,
  input logic                      const_c,
  input logic [31:0]               constant,
  input logic [3:0]                a_select,
  input cpu_pkg::operand_selects_t selects,
  input logic [1:0]                reg_write,
  input logic [3:0]                op_select,
  input logic                      st,
  input logic                      ld,
  input logic [3:0]                mem_loca_addr,
  input logic [3:0]                reg_addr,
  input logic [31:0]               pc
);

  int          fail_count = 0; // polled by the testbench
  logic [31:0] jump_target;
  logic [67:0] alu_expect;
  logic [67:0] alu_seen;

  // the ALU constant is bits 27..12 sign-extended when bit 30 is set and zero otherwise
  assign jump_target = instruction[30] ? {{16{instruction[27]}}, instruction[27:12]} : 32'd0;

  // y1 and y2 reuse the d and c fields
  assign alu_expect = {instruction[7], instruction[6:5], instruction[11:8], instruction[11:8],
                       instruction[15:12], instruction[30], jump_target, instruction[19:16],
                       instruction[23:20], instruction[27:24], instruction[27:24],
                       instruction[23:20]};
  assign alu_seen   = {alu_form, alu_vec_perci, alu_config, op_select, a_select, const_c,
                       constant, selects};

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reset and halt
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_reset_pc: assert property (@(posedge clk) $past(reset) |-> pc == `CPU_RESET_VECTOR)
    else begin
      fail_count++;
      $error("MISMATCH at %0t: pc expected %h got %h", $time, `CPU_RESET_VECTOR, pc);
    end

  a_quiet: assert property (@(posedge clk) ($past(reset) || $past(halt)) |->
      {pc_inc, pc_jump, ld, st, trap, reg_write} == 7'd0)
    else begin
      fail_count++;
      $error("strobe active at %0t after reset or halt", $time);
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // execute cycle
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_alu_write: assert property (@(posedge clk) disable iff (reset)
      pc_inc && instruction[0] |-> reg_write == instruction[29:28])
    else begin
      fail_count++;
      $error("MISMATCH at %0t: reg_write expected %0h got %0h",
        $time, instruction[29:28], reg_write);
    end

  a_alu_op: assert property (@(posedge clk) disable iff (reset)
      pc_inc && instruction[0] |-> opcode == instruction[4:2])
    else begin
      fail_count++;
      $error("MISMATCH at %0t: opcode expected %0h got %0h", $time, instruction[4:2], opcode);
    end

  a_alu_fields: assert property (@(posedge clk) disable iff (reset)
      pc_inc && instruction[0] |-> alu_seen == alu_expect)
    else begin
      fail_count++;
      $error("MISMATCH at %0t: %s expected %h got %h", $time, "ALU field outputs",
        alu_expect, alu_seen);
    end

  a_mem_fields: assert property (@(posedge clk) disable iff (reset)
      pc_inc && !instruction[0] |-> {opcode, op_select, a_select, reg_write} ==
      {instruction[14:12], instruction[18:15], instruction[7:4], instruction[20:19]})
    else begin
      fail_count++;
      $error("MISMATCH at %0t: %s expected %h got %h", $time,
        "opcode/op_select/a_select/reg_write",
        {instruction[14:12], instruction[18:15], instruction[7:4], instruction[20:19]},
        {opcode, op_select, a_select, reg_write});
    end

  a_single_inc: assert property (@(posedge clk) disable iff (reset) pc_inc |=> !pc_inc)
    else begin
      fail_count++;
      $error("pc_inc high two cycles in a row at %0t", $time);
    end

  a_step: assert property (@(posedge clk) disable iff (reset || halt)
      pc_inc && !instruction[1] |=> pc == $past(pc) + `CPU_PC_STEP)
    else begin
      fail_count++;
      $error("MISMATCH at %0t: pc expected %h got %h", $time, $past(pc) + `CPU_PC_STEP, pc);
    end

  a_jump: assert property (@(posedge clk) disable iff (reset || halt)
      pc_inc && instruction[1] |=> pc == $past(jump_target))
    else begin
      fail_count++;
      $error("MISMATCH at %0t: pc expected %h got %h", $time, $past(jump_target), pc);
    end

  a_legal_alu: assert property (@(posedge clk) disable iff (reset)
      pc_inc && instruction[0] |-> !instruction[31] && instruction[4:2] != 3'b111)
    else begin
      fail_count++;
      $error("illegal ALU word executed at %0t", $time);
    end

  a_legal_mem: assert property (@(posedge clk) disable iff (reset)
      (pc_inc || ld || st) && !instruction[0] |->
      instruction[31:21] == 11'd0 && !(instruction[2] && instruction[3]))
    else begin
      fail_count++;
      $error("illegal memory word accepted at %0t", $time);
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory waits, traps, exclusivity
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_mem_hold: assert property (@(posedge clk) disable iff (reset || halt)
      (ld || st) && wait_data && !data_segv |=> (ld || st) && !pc_inc)
    else begin
      fail_count++;
      $error("memory strobe dropped under wait_data at %0t", $time);
    end

  a_mem_done: assert property (@(posedge clk) disable iff (reset || halt)
      (ld || st) && !wait_data && !data_segv |=> pc_inc &&
      mem_loca_addr == $past(instruction[11:8]) && reg_addr == $past(instruction[7:4]))
    else begin
      fail_count++;
      $error("MISMATCH at %0t: %s expected %h/%h got %h/%h", $time, "mem_loca_addr/reg_addr",
        $past(instruction[11:8]), $past(instruction[7:4]), mem_loca_addr, reg_addr);
    end

  a_trap_quiet: assert property (@(posedge clk) disable iff (reset)
      trap |-> !pc_inc && !ld && !st)
    else begin
      fail_count++;
      $error("strobe active during trap at %0t", $time);
    end

  a_trap_vector: assert property (@(posedge clk) disable iff (reset || halt)
      trap && go |=> pc == `CPU_TRAP_VECTOR)
    else begin
      fail_count++;
      $error("MISMATCH at %0t: pc expected %h got %h", $time, `CPU_TRAP_VECTOR, pc);
    end

  a_ld_st: assert property (@(posedge clk) disable iff (reset) !(ld && st))
    else begin
      fail_count++;
      $error("ld and st high together at %0t", $time);
    end

  a_write_gate: assert property (@(posedge clk) disable iff (reset) reg_write != 2'd0 |-> pc_inc)
    else begin
      fail_count++;
      $error("reg_write without pc_inc at %0t", $time);
    end

  // an execute cycle straight from fetch needs wait_instr low the cycle before
  a_fetch_wait: assert property (@(posedge clk) disable iff (reset)
      pc_inc && !$past(ld) && !$past(st) |-> !$past(wait_instr))
    else begin
      fail_count++;
      $error("instruction executed under wait_instr at %0t", $time);
    end

endmodule

bind control_unit_top control_unit_assert checks (.*);

/* test/control_unit_tb.sv */
module control_unit_tb;

  logic                      clk;
  logic                      reset;
  logic                      go;
  logic                      halt;
  logic [31:0]               instruction;
  logic                      instr_segv;
  logic                      data_segv;
  logic                      wait_instr;
  logic                      wait_data;
  logic                      pc_inc;
  logic                      pc_jump;
  logic                      trap;
  logic [2:0]                opcode;
  logic                      alu_form;
  logic [1:0]                alu_vec_perci;
  logic [3:0]                alu_config;
  logic                      const_c;
  logic [31:0]               constant;
  logic [3:0]                a_select;
  cpu_pkg::operand_selects_t selects;
  logic [1:0]                reg_write;
  logic [3:0]                op_select;
  logic                      st;
  logic                      ld;
  logic [3:0]                mem_loca_addr;
  logic [3:0]                reg_addr;
  logic [31:0]               pc;
  integer                    seed;

  control_unit_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // an assertion failure ends the run at the next falling edge
  initial begin
    forever begin
      @(negedge clk);
      if (UUT.checks.fail_count != 0) begin
        $display("Done: errors found");
        $fatal(1, "assertion failure");
      end
    end
  end

  // sel 0 waits for pc_inc, 1 for trap, 2 for ld or st
  task automatic wait_for(input int sel, input int limit, input string what);
    int   n;
    logic hit;
    n = 0;
    hit = 1'b0;
    while (!hit) begin
      @(negedge clk);
      case (sel)
        0: hit = pc_inc;
        1: hit = trap;
        default: hit = ld | st;
      endcase
      n++;
      if (!hit && n >= limit) begin
        $display("timeout: %s did not appear within %0d cycles", what, limit);
        $display("Done: errors found");
        $fatal(1, "timeout");
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  function automatic logic [31:0] legal_alu(input logic [31:0] r, input logic jump);
    logic [31:0] w;
    w = r;
    w[0] = 1'b1;
    w[1] = jump;
    w[31] = 1'b0;
    if (w[4:2] == 3'b111) w[4:2] = 3'b010;
    return w;
  endfunction

  function automatic logic [31:0] legal_mem(input logic [31:0] r, input logic l, input logic s);
    logic [31:0] w;
    w = r;
    w[0] = 1'b0;
    w[2] = l;
    w[3] = s;
    w[31:21] = 11'd0;
    return w;
  endfunction

  // execute one word to its pc_inc and give the PC a clock to update
  task automatic run_word(input logic [31:0] w);
    instruction = w;
    wait_for(0, 20, "pc_inc");
    idle(1);
  endtask

  // the restart word runs to completion before the next word is applied
  task automatic restart_from_trap();
    go = 1'b1;
    instruction = legal_alu(32'd0, 1'b0);
    instr_segv = 1'b0;
    data_segv = 1'b0;
    idle(1);
    go = 1'b0;
    wait_for(0, 20, "pc_inc after restart");
    idle(1);
  endtask

  initial begin
    seed = 32'h0906_06b2;
    reset = 1'b1;
    go = 1'b0;
    halt = 1'b1;
    instruction = 32'd0;
    instr_segv = 1'b0;
    data_segv = 1'b0;
    wait_instr = 1'b0;
    wait_data = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    idle(3);
    halt = 1'b0;
    go = 1'b1;
    idle(1);
    go = 1'b0;

    // ALU words with some jumps among them
    repeat (12) run_word(legal_alu($random(seed), $random(seed) % 4 == 0));

    // loads and stores held by wait_data and then a register move
    repeat (3) begin
      instruction = legal_mem($random(seed), 1'b1, 1'b0);
      wait_data = 1'b1;
      wait_for(2, 20, "ld");
      idle(3);
      wait_data = 1'b0;
      wait_for(0, 20, "pc_inc after load");
      idle(1);
      instruction = legal_mem($random(seed), 1'b0, 1'b1);
      wait_data = 1'b1;
      wait_for(2, 20, "st");
      idle(2);
      wait_data = 1'b0;
      wait_for(0, 20, "pc_inc after store");
      idle(1);
    end
    run_word(legal_mem($random(seed), 1'b0, 1'b0));

    // wait_instr holds fetch
    wait_instr = 1'b1;
    instruction = legal_alu($random(seed), 1'b0);
    idle(5);
    wait_instr = 1'b0;
    wait_for(0, 20, "pc_inc after wait_instr");
    idle(1);

    // traps from illegal words and both segv inputs
    instruction = legal_alu($random(seed), 1'b0) | 32'h8000_0000;
    wait_for(1, 20, "trap on bit 31");
    idle(2);
    restart_from_trap();
    instruction = legal_alu($random(seed), 1'b0) | 32'h0000_001c;
    wait_for(1, 20, "trap on reserved ALU op");
    restart_from_trap();
    instruction = legal_mem($random(seed), 1'b0, 1'b0) | 32'h0020_0000;
    wait_for(1, 20, "trap on upper memory bits");
    restart_from_trap();
    instruction = legal_mem($random(seed), 1'b1, 1'b1);
    wait_for(1, 20, "trap on ld with st");
    restart_from_trap();
    instr_segv = 1'b1;
    instruction = legal_alu($random(seed), 1'b0);
    wait_for(1, 20, "trap on instr_segv");
    restart_from_trap();
    instruction = legal_mem($random(seed), 1'b1, 1'b0);
    wait_data = 1'b1;
    wait_for(2, 20, "ld before data_segv");
    data_segv = 1'b1;
    wait_data = 1'b0;
    wait_for(1, 20, "trap on data_segv");
    restart_from_trap();
    run_word(legal_alu($random(seed), 1'b0));

    // halt at the end
    halt = 1'b1;
    idle(4);

    if (UUT.checks.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "assertion failure");
    end
  end

endmodule

/* compile.f */
+incdir+rtl
rtl/cpu_pkg.sv
rtl/alu_instruction_decoder.sv
rtl/mmu_decoder.sv
rtl/control_fsm.sv
rtl/controlpath.sv
rtl/program_counter.sv
rtl/control_unit_top.sv
test/control_unit_assert.sv
test/control_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, then run and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  --top-module control_unit_tb -f compile.f -o control_unit_sim &&
./obj_dir/control_unit_sim | tee /dev/stderr | grep -q "Done: no errors" &&
echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
